//--- hw/store_pkg.sv
`default_nettype none

package store_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    typedef logic [31:0] word_t;     // data or byte address
    typedef logic [4:0]  rob_tag_t;  // reorder buffer index
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  byte_en_t;  // one bit per byte lane

    // ------------------------------------------------------------------
    // instruction encodings
    // ------------------------------------------------------------------
    localparam opcode_t OPC_STORE = 7'b0100011;

    // only word and halfword stores are handled here
    localparam funct3_t F3_SW = 3'b010;
    localparam funct3_t F3_SH = 3'b001;

    // ------------------------------------------------------------------
    // commit side
    // ------------------------------------------------------------------
    typedef enum logic {
        CS_IDLE,  // memory port empty
        CS_WRITE  // write presented until mem_ready
    } commit_state_t;

endpackage

`default_nettype wire

//--- hw/store_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module store_dispatch #(
    parameter int DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,

    // issue port
    input  logic                 in_valid,
    output logic                 in_ready,
    input  store_pkg::opcode_t   in_opcode,
    input  store_pkg::funct3_t   in_funct3,
    input  store_pkg::word_t     in_base,
    input  store_pkg::word_t     in_imm,
    input  store_pkg::word_t     in_data,
    input  store_pkg::rob_tag_t  in_rob_tag,

    // queue slots
    input  logic [DEPTH-1:0]     slot_valid,
    output logic [DEPTH-1:0]     alloc,
    output store_pkg::word_t     alloc_addr,
    output store_pkg::word_t     alloc_data,
    output store_pkg::rob_tag_t  alloc_tag,
    output logic                 alloc_half
);

    import store_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    logic [PTR_W-1:0] wr_ptr;
    logic             take;      // issue handshake this cycle
    logic             is_store;  // sw or sh

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    // a full queue stalls non-stores too
    assign in_ready = ~slot_valid[wr_ptr];
    assign take     = in_valid & in_ready;

    assign is_store = (in_opcode == OPC_STORE) &&
                      ((in_funct3 == F3_SW) || (in_funct3 == F3_SH));

    // ------------------------------------------------------------------
    // slot allocation
    // ------------------------------------------------------------------
    always_comb begin
        alloc = '0;
        if (take && is_store) begin
            alloc[wr_ptr] = 1'b1;
        end
    end

    // only the strobed slot captures the shared payload
    assign alloc_addr = in_base + in_imm;  // effective address
    assign alloc_data = in_data;
    assign alloc_tag  = in_rob_tag;
    assign alloc_half = (in_funct3 == F3_SH);

    // write pointer moves only for real stores
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (take && is_store) begin
            if (wr_ptr == PTR_LAST) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/store_entry.sv
`timescale 1ns/10ps
`default_nettype none

module store_entry (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc,
    input  logic                 release_slot,
    input  store_pkg::word_t     alloc_addr,
    input  store_pkg::word_t     alloc_data,
    input  store_pkg::rob_tag_t  alloc_tag,
    input  logic                 alloc_half,
    output logic                 valid,
    output store_pkg::word_t     addr,
    output store_pkg::word_t     wdata,
    output store_pkg::byte_en_t  be,
    output store_pkg::rob_tag_t  tag
);

    import store_pkg::*;

    word_t    fmt_addr;
    word_t    fmt_data;
    byte_en_t fmt_be;

    // format for the memory bus before capture
    always_comb begin
        fmt_addr = {alloc_addr[31:2], 2'b00};  // misaligned just rounds down
        if (!alloc_half) begin
            fmt_data = alloc_data;
            fmt_be   = 4'b1111;
        end else if (alloc_addr[1]) begin
            // upper halfword lane
            fmt_data = {alloc_data[15:0], 16'h0000};
            fmt_be   = 4'b1100;
        end else begin
            fmt_data = {16'h0000, alloc_data[15:0]};
            fmt_be   = 4'b0011;
        end
    end

    // alloc and release never land on one slot in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end else if (release_slot) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            addr  <= fmt_addr;
            wdata <= fmt_data;
            be    <= fmt_be;
            tag   <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/store_commit.sv
`timescale 1ns/10ps
`default_nettype none

module store_commit #(
    parameter int DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             reset,

    // queue slots
    input  logic [DEPTH-1:0]                 slot_valid,
    input  store_pkg::word_t [DEPTH-1:0]     slot_addr,
    input  store_pkg::word_t [DEPTH-1:0]     slot_wdata,
    input  store_pkg::byte_en_t [DEPTH-1:0]  slot_be,
    input  store_pkg::rob_tag_t [DEPTH-1:0]  slot_tag,
    output logic [DEPTH-1:0]                 release_slot,

    // retire port from the reorder buffer
    input  logic                             retire_valid,
    output logic                             retire_ready,
    input  store_pkg::rob_tag_t              retire_tag,

    // data memory write port
    output logic                             mem_valid,
    input  logic                             mem_ready,
    output store_pkg::word_t                 mem_addr,
    output store_pkg::word_t                 mem_wdata,
    output store_pkg::byte_en_t              mem_be
);

    import store_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    logic [PTR_W-1:0] rd_ptr;
    commit_state_t    state;
    logic             head_valid;
    rob_tag_t         head_tag;
    logic             port_free;    // a new write can be registered this edge
    logic             retire_take;

    // ------------------------------------------------------------------
    // head of queue
    // ------------------------------------------------------------------
    assign head_valid = slot_valid[rd_ptr];
    assign head_tag   = slot_tag[rd_ptr];

    // pending write leaves on this edge when mem_ready is high
    assign port_free    = (state == CS_IDLE) || mem_ready;
    assign retire_ready = head_valid && (head_tag == retire_tag) && port_free;
    assign retire_take  = retire_valid & retire_ready;

    always_comb begin
        release_slot = '0;
        if (retire_take) begin
            release_slot[rd_ptr] = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // state and read pointer
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= CS_IDLE;
            rd_ptr <= '0;
        end else if (retire_take) begin
            state <= CS_WRITE;  // also covers back to back writes
            if (rd_ptr == PTR_LAST) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end else if (state == CS_WRITE && mem_ready) begin
            state <= CS_IDLE;
        end
    end

    assign mem_valid = (state == CS_WRITE);

    // payload held until the next retire
    always_ff @(posedge clk) begin
        if (retire_take) begin
            mem_addr  <= slot_addr[rd_ptr];
            mem_wdata <= slot_wdata[rd_ptr];
            mem_be    <= slot_be[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- hw/store_queue.sv
`timescale 1ns/10ps
`default_nettype none

module store_queue #(
    parameter int DEPTH = 8  // power of two
) (
    input  logic                 clk,
    input  logic                 reset,

    // issue
    input  logic                 in_valid,
    output logic                 in_ready,
    input  store_pkg::opcode_t   in_opcode,
    input  store_pkg::funct3_t   in_funct3,
    input  store_pkg::word_t     in_base,
    input  store_pkg::word_t     in_imm,
    input  store_pkg::word_t     in_data,
    input  store_pkg::rob_tag_t  in_rob_tag,

    // retire
    input  logic                 retire_valid,
    output logic                 retire_ready,
    input  store_pkg::rob_tag_t  retire_tag,

    // memory write
    output logic                 mem_valid,
    input  logic                 mem_ready,
    output store_pkg::word_t     mem_addr,
    output store_pkg::word_t     mem_wdata,
    output store_pkg::byte_en_t  mem_be
);

    import store_pkg::*;

    logic [DEPTH-1:0]     slot_valid;
    logic [DEPTH-1:0]     alloc;
    logic [DEPTH-1:0]     release_slot;
    word_t [DEPTH-1:0]    slot_addr;
    word_t [DEPTH-1:0]    slot_wdata;
    byte_en_t [DEPTH-1:0] slot_be;
    rob_tag_t [DEPTH-1:0] slot_tag;

    // shared fill bus
    word_t    alloc_addr;
    word_t    alloc_data;
    rob_tag_t alloc_tag;
    logic     alloc_half;

    store_dispatch #(
        .DEPTH (DEPTH)
    ) u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_opcode  (in_opcode),
        .in_funct3  (in_funct3),
        .in_base    (in_base),
        .in_imm     (in_imm),
        .in_data    (in_data),
        .in_rob_tag (in_rob_tag),
        .slot_valid (slot_valid),
        .alloc      (alloc),
        .alloc_addr (alloc_addr),
        .alloc_data (alloc_data),
        .alloc_tag  (alloc_tag),
        .alloc_half (alloc_half)
    );

    // ------------------------------------------------------------------
    // slots
    // ------------------------------------------------------------------
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        store_entry u_entry (
            .clk          (clk),
            .reset        (reset),
            .alloc        (alloc[i]),
            .release_slot (release_slot[i]),
            .alloc_addr   (alloc_addr),
            .alloc_data   (alloc_data),
            .alloc_tag    (alloc_tag),
            .alloc_half   (alloc_half),
            .valid        (slot_valid[i]),
            .addr         (slot_addr[i]),
            .wdata        (slot_wdata[i]),
            .be           (slot_be[i]),
            .tag          (slot_tag[i])
        );
    end

    store_commit #(
        .DEPTH (DEPTH)
    ) u_commit (
        .clk          (clk),
        .reset        (reset),
        .slot_valid   (slot_valid),
        .slot_addr    (slot_addr),
        .slot_wdata   (slot_wdata),
        .slot_be      (slot_be),
        .slot_tag     (slot_tag),
        .release_slot (release_slot),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_tag   (retire_tag),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_be       (mem_be)
    );

endmodule

`default_nettype wire

//--- tb/store_queue_checker.sv
`timescale 1ns/10ps
`default_nettype none

module store_queue_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic                 in_ready,
    input  store_pkg::opcode_t   in_opcode,
    input  store_pkg::funct3_t   in_funct3,
    input  store_pkg::word_t     in_base,
    input  store_pkg::word_t     in_imm,
    input  store_pkg::word_t     in_data,
    input  logic                 retire_valid,
    input  logic                 retire_ready,
    input  logic                 mem_valid,
    input  logic                 mem_ready,
    input  store_pkg::word_t     mem_addr,
    input  store_pkg::word_t     mem_wdata,
    input  store_pkg::byte_en_t  mem_be,
    output int                   error_count,
    output int                   write_count,
    output int                   pending_count
);

    import store_pkg::*;

    // rv32i encodings
    localparam opcode_t STORE_OP = 7'b0100011;
    localparam funct3_t WORD_F3  = 3'd2;
    localparam funct3_t HALF_F3  = 3'd1;

    word_t    exp_addr [$];
    word_t    exp_data [$];
    byte_en_t exp_be [$];
    int       retires = 0;

    initial begin
        error_count   = 0;
        write_count   = 0;
        pending_count = 0;
    end

    task automatic expect_store();
        word_t    ea;
        word_t    data;
        byte_en_t be;
        int       shift;
        ea    = in_base + in_imm;
        shift = ea[1] ? 16 : 0;  // halfword lane
        if (in_funct3 == WORD_F3) begin
            data = in_data;
            be   = 4'b1111;
        end else begin
            data = {16'h0000, in_data[15:0]} << shift;
            be   = 4'b0011 << (shift / 8);
        end
        exp_addr.push_back(ea & 32'hffff_fffc);
        exp_data.push_back(data);
        exp_be.push_back(be);
    endtask

    task automatic check_write();
        if (exp_addr.size() == 0) begin
            error_count++;
            $display("error at %0t: write to %h with no store pending", $time, mem_addr);
        end else begin
            if (mem_addr !== exp_addr[0] || mem_wdata !== exp_data[0] || mem_be !== exp_be[0]) begin
                error_count++;
                $display("error at %0t: write %0d got %h %h %b, expected %h %h %b", $time,
                         write_count, mem_addr, mem_wdata, mem_be,
                         exp_addr[0], exp_data[0], exp_be[0]);
            end
            exp_addr.delete(0);
            exp_data.delete(0);
            exp_be.delete(0);
        end
        write_count++;
    endtask

    // ----------------------------------------------------------------------
    // handshakes seen at the clock edge
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            if (mem_valid && retires == 0) begin
                error_count++;
                $display("error at %0t: mem_valid high before the first retire", $time);
            end
            if (in_valid && in_ready && in_opcode == STORE_OP &&
                (in_funct3 == WORD_F3 || in_funct3 == HALF_F3)) begin
                expect_store();
            end
            if (retire_valid && retire_ready) begin
                retires++;
            end
            if (mem_valid && mem_ready) begin
                check_write();
            end
        end
        pending_count = exp_addr.size();
    end

endmodule

`default_nettype wire

//--- tb/store_queue_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module store_queue_assertions #(
    parameter int DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_ready,
    input  logic [DEPTH-1:0]     slot_valid,
    input  logic                 retire_ready,
    input  logic                 mem_valid,
    input  logic                 mem_ready,
    input  store_pkg::word_t     mem_addr,
    input  store_pkg::word_t     mem_wdata,
    input  store_pkg::byte_en_t  mem_be
);

    int fail_count = 0;

    // a stalled write keeps its payload
    payload_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_valid && !mem_ready) |=>
            (mem_valid && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_be)))
        else begin
            fail_count++;
            $error("memory payload changed while mem_ready was low");
        end

    full_stalls: assert property (@(posedge clk) disable iff (reset)
        (&slot_valid) |-> !in_ready)
        else begin
            fail_count++;
            $error("in_ready high with every slot valid");
        end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!mem_valid && !retire_ready))
        else begin
            fail_count++;
            $error("mem_valid or retire_ready high right after reset");
        end

endmodule

bind store_queue store_queue_assertions #(
    .DEPTH (DEPTH)
) u_assertions (
    .clk          (clk),
    .reset        (reset),
    .in_ready     (in_ready),
    .slot_valid   (slot_valid),
    .retire_ready (retire_ready),
    .mem_valid    (mem_valid),
    .mem_ready    (mem_ready),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_be       (mem_be)
);

`default_nettype wire

//--- tb/store_queue_tb.sv
`timescale 1ns/10ps
`default_nettype none

module store_queue_tb;

    import store_pkg::*;

    localparam int DEPTH      = 8;
    localparam int NUM_ROWS   = 16;
    localparam int WAIT_LIMIT = 200;  // cycles per wait

    typedef struct packed {
        opcode_t  opcode;
        funct3_t  funct3;
        word_t    base;
        word_t    imm;
        word_t    data;
        rob_tag_t tag;
        logic     writes;  // row should reach memory
    } row_t;

    logic        clk;
    logic        reset;
    logic        in_valid, in_ready, retire_valid, retire_ready, mem_valid, mem_ready;
    opcode_t     in_opcode;
    funct3_t     in_funct3;
    word_t       in_base, in_imm, in_data, mem_addr, mem_wdata;
    rob_tag_t    in_rob_tag, retire_tag;
    byte_en_t    mem_be;
    int          error_count, write_count, pending_count;  // from the checker
    int          tb_errors;
    int          expected_writes;
    int          wait_cycles;
    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr;

    store_queue #(.DEPTH(DEPTH)) uut (.*);

    store_queue_checker u_checker (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // memory back pressure
    // ----------------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    always @(negedge clk) begin
        if (reset) begin
            mem_ready = 1'b0;
        end else begin
            lfsr      = lfsr_step(lfsr);
            mem_ready = lfsr[0];
        end
    end

    task automatic issue_row(input row_t r);
        int cycles;
        in_opcode  = r.opcode;
        in_funct3  = r.funct3;
        in_base    = r.base;
        in_imm     = r.imm;
        in_data    = r.data;
        in_rob_tag = r.tag;
        in_valid   = 1'b1;
        cycles     = 0;
        #1;
        while (!in_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!in_ready) begin
            tb_errors++;
            $display("timeout: issue with rob tag %0d was never accepted", r.tag);
        end
        @(negedge clk);  // taken on the edge before
        in_valid = 1'b0;
    endtask

    task automatic retire_one(input rob_tag_t t);
        int cycles;
        retire_tag   = t;
        retire_valid = 1'b1;
        cycles       = 0;
        #1;
        while (!retire_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!retire_ready) begin
            tb_errors++;
            $display("timeout: retire of rob tag %0d was never accepted", t);
        end
        @(negedge clk);
        retire_valid = 1'b0;
    endtask

    // retires wait until the queue has filled once
    task automatic retire_rows();
        int cycles;
        int i;
        cycles = 0;
        #1;
        while (in_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (in_ready) begin
            tb_errors++;
            $display("in_ready never went low although more stores than slots were issued");
        end
        @(negedge clk);
        for (i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].writes) begin
                retire_one(rows[i].tag);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_opcode    = '0;
        in_funct3    = '0;
        in_base      = '0;
        in_imm       = '0;
        in_data      = '0;
        in_rob_tag   = '0;
        retire_valid = 1'b0;
        retire_tag   = '0;
        mem_ready    = 1'b0;
        lfsr         = 16'd49406;
        tb_errors    = 0;
        rows[0]  = '{OPC_STORE, F3_SW, 32'h0000_1000, 32'h0000_0004, 32'h1122_3344, 5'd1, 1'b1};
        rows[1]  = '{OPC_STORE, F3_SH, 32'h0000_2000, 32'h0000_0000, 32'haaaa_5566, 5'd2, 1'b1};
        rows[2]  = '{7'h33, F3_SW, 32'h0000_2000, 32'h0000_0008, 32'hdead_beef, 5'd3, 1'b0};
        rows[3]  = '{OPC_STORE, F3_SH, 32'h0000_2000, 32'h0000_0002, 32'h1234_beef, 5'd4, 1'b1};
        rows[4]  = '{OPC_STORE, F3_SW, 32'h0000_3001, 32'h0000_0002, 32'hcafe_f00d, 5'd5, 1'b1};
        rows[5]  = '{OPC_STORE, 3'b000, 32'h0000_3000, 32'h0000_0000, 32'h0000_00ff, 5'd6, 1'b0};
        rows[6]  = '{OPC_STORE, F3_SW, 32'hffff_fff0, 32'h0000_0020, 32'h0bad_c0de, 5'd7, 1'b1};
        rows[7]  = '{OPC_STORE, F3_SH, 32'h0000_4000, 32'hffff_fffe, 32'h0000_7777, 5'd8, 1'b1};
        rows[8]  = '{OPC_STORE, F3_SW, 32'h0000_5000, 32'h0000_0000, 32'h5555_aaaa, 5'd9, 1'b1};
        rows[9]  = '{OPC_STORE, F3_SH, 32'h0000_5003, 32'h0000_0000, 32'hffff_1357, 5'd10, 1'b1};
        rows[10] = '{OPC_STORE, F3_SW, 32'h0000_6000, 32'h0000_0010, 32'h0102_0304, 5'd11, 1'b1};
        rows[11] = '{7'h03, F3_SW, 32'h0000_6000, 32'h0000_0000, 32'h0000_0000, 5'd12, 1'b0};
        rows[12] = '{OPC_STORE, F3_SH, 32'h0000_7000, 32'h0000_0001, 32'h8888_2468, 5'd13, 1'b1};
        rows[13] = '{OPC_STORE, 3'b011, 32'h0000_7000, 32'h0000_0004, 32'h0000_0001, 5'd14, 1'b0};
        rows[14] = '{OPC_STORE, F3_SW, 32'h0000_8000, 32'hffff_fffc, 32'h7654_3210, 5'd15, 1'b1};
        rows[15] = '{OPC_STORE, F3_SH, 32'h0000_9000, 32'h0000_0006, 32'h0000_abcd, 5'd16, 1'b1};
        expected_writes = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].writes) begin
                expected_writes++;
            end
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;  // lfsr starts on the next falling edge

        fork
            begin
                for (int i = 0; i < NUM_ROWS; i++) begin
                    issue_row(rows[i]);
                end
            end
            retire_rows();
        join

        wait_cycles = 0;
        while (write_count < expected_writes && wait_cycles < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (write_count < expected_writes) begin
            tb_errors++;
            $display("timeout: only %0d of %0d memory writes arrived", write_count,
                     expected_writes);
        end
        repeat (4) @(negedge clk);  // room for a stray write
        if (pending_count != 0) begin
            tb_errors++;
            $display("%0d decoded stores never reached memory", pending_count);
        end

        $display("summary: %0d writes, %0d checker errors, %0d assertion failures, %0d tb errors",
                 write_count, error_count, uut.u_assertions.fail_count, tb_errors);
        if (error_count == 0 && tb_errors == 0 && uut.u_assertions.fail_count == 0 &&
            write_count == expected_writes) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- store_queue.f
hw/store_pkg.sv
hw/store_dispatch.sv
hw/store_entry.sv
hw/store_commit.sv
hw/store_queue.sv
tb/store_queue_checker.sv
tb/store_queue_assertions.sv
tb/store_queue_tb.sv
